// ==== design/fetch_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                flush,
    input  logic                enable,
    input  logic                interrupt,
    input  zpu_decode_pkg::pc_t new_pc,
    input  zpu_decode_pkg::pc_t int_addr,
    output zpu_decode_pkg::pc_t fetch_addr,
    output logic                fetch_en,
    output logic                int_ack,
    fetch_if.ctrl               fif
);
    import zpu_decode_pkg::*;

    pc_t  pc;
    pc_t  next_pc;
    pc_t  vector_pc;
    logic wait_pre;
    logic wait_inst;
    logic idim;
    logic int_busy;
    logic hold;
    logic run;

    assign next_pc   = pc + pc_t'(1);
    assign vector_pc = pc_t'(fif.opcode[4:0]) << EMU_VECTOR_SHIFT;
    assign hold      = stall && !flush;
    assign run       = !flush && !stall && enable && !wait_inst;  // Word for pc is on mem_data

    assign fif.pc         = pc;
    assign fif.idim       = idim;
    assign fif.take_int   = run && interrupt && !int_busy && !idim;
    assign fif.decode_now = run && !fif.take_int;
    assign fif.bubble     = !hold && !run;

    assign int_ack  = int_busy;
    assign fetch_en = flush || (enable && (wait_inst || !stall));

    //////////////////////////////
    // Fetch address
    always_comb begin
        if (flush) begin
            fetch_addr = new_pc;
        end else if (fif.take_int) begin
            fetch_addr = int_addr;
        end else if (!fif.decode_now) begin
            fetch_addr = pc;  // Waiting, stalled or disabled
        end else begin
            case (fif.pc_action)
                HOLD:    fetch_addr = pc;
                VECTOR:  fetch_addr = vector_pc;
                default: fetch_addr = next_pc;
            endcase
        end
    end

    //////////////////////////////
    // PC, wait flags and IM state
    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= '0;
            wait_pre  <= 1'b1;
            wait_inst <= 1'b1;
            idim      <= 1'b0;
        end else if (flush) begin
            pc        <= new_pc;
            wait_pre  <= 1'b0;
            wait_inst <= 1'b0;
            idim      <= 1'b0;
        end else if (!stall && enable) begin
            wait_pre  <= 1'b0;
            wait_inst <= wait_pre;
            if (fif.take_int) begin
                pc        <= int_addr;
                wait_pre  <= 1'b1;
                wait_inst <= 1'b1;
            end else if (fif.decode_now) begin
                idim <= (fif.opcode[7] == INST_IM);
                case (fif.pc_action)
                    ADVANCE: pc <= next_pc;
                    VECTOR: begin
                        pc        <= vector_pc;
                        wait_pre  <= 1'b1;  // Two dead cycles for the new word
                        wait_inst <= 1'b1;
                    end
                    default: pc <= pc;      // BREAK spins in place
                endcase
            end
        end
    end

    // In progress until the request line drops
    always_ff @(posedge clk) begin
        if (rst) begin
            int_busy <= 1'b0;
        end else if (fif.take_int) begin
            int_busy <= 1'b1;
        end else if (!hold && !interrupt) begin
            int_busy <= 1'b0;
        end
    end

    a_flush_vs_int: assert property (@(posedge clk) disable iff (rst)
        !(flush && fif.take_int))
        else $error("Flush and interrupt entry in the same cycle");

    a_stall_holds_pc: assert property (@(posedge clk) disable iff (rst)
        hold |=> $stable(pc))
        else $error("PC moved during stall");

endmodule

`default_nettype wire

// ==== design/fetch_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface fetch_if;
    import zpu_decode_pkg::*;

    pc_t        pc;
    logic       idim;        // Previous instruction was an IM
    logic       decode_now;
    logic       bubble;      // Issue a NOP
    logic       take_int;    // Interrupt entry this cycle
    opcode_t    opcode;
    pc_action_t pc_action;

    modport ctrl (
        output pc, idim, decode_now, bubble, take_int,
        input  opcode, pc_action
    );

    modport dec (
        input  pc, idim,
        output opcode, pc_action
    );

    modport issue (
        input pc, decode_now, bubble, take_int, opcode
    );

endinterface

`default_nettype wire

// ==== design/issue_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue_regs (
    input  logic                     clk,
    input  logic                     rst,
    fetch_if.issue                   fif,
    input  zpu_decode_pkg::exe_op_t  exe_op,
    input  zpu_decode_pkg::sp_step_t sp_step,
    input  zpu_decode_pkg::sp_src_t  sp_src,
    output zpu_decode_pkg::exe_op_t  decoded_op,
    output zpu_decode_pkg::sp_step_t spstate,
    output zpu_decode_pkg::sp_src_t  spsource,
    output zpu_decode_pkg::offset_t  offset,
    output zpu_decode_pkg::instval_t inst_value,
    output zpu_decode_pkg::pc_t      pc_out,
    output zpu_decode_pkg::pc_t      next_pc_out
);
    import zpu_decode_pkg::*;

    pc_t next_pc;

    assign next_pc = fif.pc + pc_t'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            decoded_op  <= NOP;
            spstate     <= STAY;
            spsource    <= STAY_SRC;
            offset      <= '0;
            inst_value  <= '0;
            pc_out      <= '0;
            next_pc_out <= '0;
        end else if (fif.take_int || fif.decode_now) begin
            offset     <= {~fif.opcode[4], fif.opcode[3:0]};
            inst_value <= fif.opcode[6:0];
            pc_out     <= fif.pc;
            if (fif.take_int) begin
                decoded_op  <= PUSHPC;
                spstate     <= DEC;
                spsource    <= STAY_SRC;
                next_pc_out <= fif.pc;  // Return to the interrupted instruction
            end else begin
                decoded_op  <= exe_op;
                spstate     <= sp_step;
                spsource    <= sp_src;
                next_pc_out <= next_pc;
            end
        end else if (fif.bubble) begin
            decoded_op <= NOP;
            spstate    <= STAY;
            spsource   <= STAY_SRC;
        end
    end

    a_outputs_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({decoded_op, spstate, spsource, offset, inst_value, pc_out, next_pc_out}))
        else $error("Unknown value on decode outputs");

endmodule

`default_nettype wire

// ==== design/opcode_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module opcode_decoder (
    input  zpu_decode_pkg::word_t    mem_data,
    fetch_if.dec                     fif,
    output zpu_decode_pkg::exe_op_t  exe_op,
    output zpu_decode_pkg::sp_step_t sp_step,
    output zpu_decode_pkg::sp_src_t  sp_src
);
    import zpu_decode_pkg::*;

    logic [1:0] lane;
    opcode_t    opcode;
    offset_t    offset;

    // Big-endian, PC lane 0 sits in the top byte
    assign lane       = ~fif.pc[1:0];
    assign opcode     = mem_data[{lane, 3'b000} +: 8];
    assign offset     = {~opcode[4], opcode[3:0]};
    assign fif.opcode = opcode;

    //////////////////////////////
    // Opcode to operation
    always_comb begin
        exe_op        = NOP;
        fif.pc_action = ADVANCE;
        if (opcode[7] == INST_IM) begin
            exe_op = fif.idim ? IMN : IM0;  // First IM pushes
        end else begin
            case (opcode[6:5])
                GRP_STORESP: begin
                    if (offset == 5'd1)
                        exe_op = STORESP1;
                    else if (offset == 5'd2)
                        exe_op = STORESP2;
                    else
                        exe_op = STORESP;
                end
                GRP_LOADSP: exe_op = LOADSP;
                GRP_EMULATE: begin
                    case (opcode[4:0])
                        INST_LOADH:            exe_op = LOADH;
                        INST_STOREH:           exe_op = STOREH;
                        INST_LOADB:            exe_op = LOADB;
                        INST_STOREB:           exe_op = STOREB;
                        INST_LESSTHAN:         exe_op = LESSTHAN;
                        INST_LESSTHANOREQUAL:  exe_op = LESSTHANOREQUAL;
                        INST_ULESSTHAN:        exe_op = ULESSTHAN;
                        INST_ULESSTHANOREQUAL: exe_op = ULESSTHANOREQUAL;
                        INST_LSHIFTRIGHT:      exe_op = LSHIFTRIGHT;
                        INST_ASHIFTLEFT:       exe_op = ASHIFTLEFT;
                        INST_ASHIFTRIGHT:      exe_op = ASHIFTRIGHT;
                        INST_CALL:             exe_op = CALL;
                        INST_EQ:               exe_op = EQ;
                        INST_NEQ:              exe_op = NEQ;
                        INST_NEG:              exe_op = NEG;
                        INST_SUB:              exe_op = SUB;
                        INST_XOR:              exe_op = XOR;
                        INST_EQBRANCH:         exe_op = EQBRANCH;
                        INST_NEQBRANCH:        exe_op = NEQBRANCH;
                        INST_POPPCREL:         exe_op = POPPCREL;
                        INST_PUSHPC:           exe_op = PUSHPC;
                        INST_PUSHSPADD:        exe_op = PUSHSPADD;
                        INST_CALLREL:          exe_op = CALLREL;
                        INST_MULT:             exe_op = MULT;
                        default: begin
                            // Software emulation entry, push return PC
                            exe_op        = PUSHPC;
                            fif.pc_action = VECTOR;
                        end
                    endcase
                end
                default: begin
                    if (opcode[4] == INST_ADDSP) begin
                        exe_op = ADDSP;
                    end else begin
                        case (opcode[3:0])
                            INST_PUSHSP: exe_op = PUSHSP;
                            INST_POPPC:  exe_op = POPPC;
                            INST_POPINT: exe_op = POPPC;
                            INST_ADD:    exe_op = ADD;
                            INST_AND:    exe_op = AND;
                            INST_OR:     exe_op = OR;
                            INST_LOAD:   exe_op = LOAD;
                            INST_NOT:    exe_op = NOT;
                            INST_FLIP:   exe_op = FLIP;
                            INST_NOP:    exe_op = NOP;
                            INST_STORE:  exe_op = STORE;
                            INST_POPSP:  exe_op = POPSP;
                            default:     fif.pc_action = HOLD;  // BREAK and unused codes
                        endcase
                    end
                end
            endcase
        end
    end

    //////////////////////////////
    // Stack pointer step and address source
    always_comb begin
        sp_step = STAY;
        sp_src  = STAY_SRC;
        case (exe_op)
            IM0, PUSHSP, PUSHPC: sp_step = DEC;
            LOADSP: begin
                sp_step = DEC;
                sp_src  = OFFSET_SRC;
            end
            ADDSP: sp_src = OFFSET_SRC;
            POPSP: begin
                sp_step = TOS;
                sp_src  = TOS_SRC;
            end
            STORESP, STORESP1, STORESP2, POPPC, STORE, ADD, AND, OR,
            STOREH, STOREB, LESSTHAN, LESSTHANOREQUAL, ULESSTHAN, ULESSTHANOREQUAL,
            LSHIFTRIGHT, ASHIFTLEFT, ASHIFTRIGHT, EQ, NEQ, SUB, XOR,
            EQBRANCH, NEQBRANCH, POPPCREL, MULT: begin
                sp_step = INC;  // Two operands in, one out
                sp_src  = INC_SRC;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/zpu_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module zpu_decode (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stall,
    input  logic                     flush,
    input  logic                     enable,
    input  logic                     interrupt,
    input  zpu_decode_pkg::pc_t      new_pc,
    input  zpu_decode_pkg::pc_t      int_addr,
    input  zpu_decode_pkg::word_t    mem_data,
    output zpu_decode_pkg::pc_t      fetch_addr,
    output logic                     fetch_en,
    output logic                     int_ack,
    output zpu_decode_pkg::exe_op_t  decoded_op,
    output zpu_decode_pkg::sp_step_t spstate,
    output zpu_decode_pkg::sp_src_t  spsource,
    output zpu_decode_pkg::offset_t  offset,
    output zpu_decode_pkg::instval_t inst_value,
    output zpu_decode_pkg::pc_t      pc_out,
    output zpu_decode_pkg::pc_t      next_pc_out
);
    import zpu_decode_pkg::*;

    exe_op_t  exe_op;
    sp_step_t sp_step;
    sp_src_t  sp_src;

    fetch_if fif ();

    fetch_ctrl u_fetch_ctrl (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .flush      (flush),
        .enable     (enable),
        .interrupt  (interrupt),
        .new_pc     (new_pc),
        .int_addr   (int_addr),
        .fetch_addr (fetch_addr),
        .fetch_en   (fetch_en),
        .int_ack    (int_ack),
        .fif        (fif)
    );

    opcode_decoder u_opcode_decoder (
        .mem_data (mem_data),
        .fif      (fif),
        .exe_op   (exe_op),
        .sp_step  (sp_step),
        .sp_src   (sp_src)
    );

    // Registered toward execute
    issue_regs u_issue_regs (
        .clk         (clk),
        .rst         (rst),
        .fif         (fif),
        .exe_op      (exe_op),
        .sp_step     (sp_step),
        .sp_src      (sp_src),
        .decoded_op  (decoded_op),
        .spstate     (spstate),
        .spsource    (spsource),
        .offset      (offset),
        .inst_value  (inst_value),
        .pc_out      (pc_out),
        .next_pc_out (next_pc_out)
    );

endmodule

`default_nettype wire

// ==== design/zpu_decode_pkg.sv ====
`default_nettype none

package zpu_decode_pkg;

    localparam int PC_W             = 32;
    localparam int EMU_VECTOR_SHIFT = 5;

    typedef logic [PC_W-1:0] pc_t;
    typedef logic [31:0]     word_t;
    typedef logic [7:0]      opcode_t;
    typedef logic [4:0]      offset_t;
    typedef logic [6:0]      instval_t;

    //////////////////////////////
    // Opcode group fields
    localparam logic       INST_IM     = 1'b1;   // Bit 7
    localparam logic [1:0] GRP_STORESP = 2'b10;  // Bits 6:5
    localparam logic [1:0] GRP_LOADSP  = 2'b11;
    localparam logic [1:0] GRP_EMULATE = 2'b01;
    localparam logic       INST_ADDSP  = 1'b1;   // Bit 4 when bits 6:5 are zero

    // Native codes, bits 3:0
    localparam logic [3:0] INST_BREAK  = 4'd0;
    localparam logic [3:0] INST_PUSHSP = 4'd2;
    localparam logic [3:0] INST_POPINT = 4'd3;
    localparam logic [3:0] INST_POPPC  = 4'd4;
    localparam logic [3:0] INST_ADD    = 4'd5;
    localparam logic [3:0] INST_AND    = 4'd6;
    localparam logic [3:0] INST_OR     = 4'd7;
    localparam logic [3:0] INST_LOAD   = 4'd8;
    localparam logic [3:0] INST_NOT    = 4'd9;
    localparam logic [3:0] INST_FLIP   = 4'd10;
    localparam logic [3:0] INST_NOP    = 4'd11;
    localparam logic [3:0] INST_STORE  = 4'd12;
    localparam logic [3:0] INST_POPSP  = 4'd13;

    // Emulated codes, bits 4:0
    localparam logic [4:0] INST_LOADH            = 5'd2;
    localparam logic [4:0] INST_STOREH           = 5'd3;
    localparam logic [4:0] INST_LESSTHAN         = 5'd4;
    localparam logic [4:0] INST_LESSTHANOREQUAL  = 5'd5;
    localparam logic [4:0] INST_ULESSTHAN        = 5'd6;
    localparam logic [4:0] INST_ULESSTHANOREQUAL = 5'd7;
    localparam logic [4:0] INST_MULT             = 5'd9;
    localparam logic [4:0] INST_LSHIFTRIGHT      = 5'd10;
    localparam logic [4:0] INST_ASHIFTLEFT       = 5'd11;
    localparam logic [4:0] INST_ASHIFTRIGHT      = 5'd12;
    localparam logic [4:0] INST_CALL             = 5'd13;
    localparam logic [4:0] INST_EQ               = 5'd14;
    localparam logic [4:0] INST_NEQ              = 5'd15;
    localparam logic [4:0] INST_NEG              = 5'd16;
    localparam logic [4:0] INST_SUB              = 5'd17;
    localparam logic [4:0] INST_XOR              = 5'd18;
    localparam logic [4:0] INST_LOADB            = 5'd19;
    localparam logic [4:0] INST_STOREB           = 5'd20;
    localparam logic [4:0] INST_EQBRANCH         = 5'd23;
    localparam logic [4:0] INST_NEQBRANCH        = 5'd24;
    localparam logic [4:0] INST_POPPCREL         = 5'd25;
    localparam logic [4:0] INST_PUSHPC           = 5'd27;
    localparam logic [4:0] INST_PUSHSPADD        = 5'd29;
    localparam logic [4:0] INST_CALLREL          = 5'd31;

    //////////////////////////////
    // Decode results
    typedef enum logic [5:0] {
        NOP, IM0, IMN, STORESP, STORESP1, STORESP2, LOADSP, ADDSP,
        POPPC, LOAD, STORE, PUSHSP, POPSP, ADD, AND, OR, NOT, FLIP, PUSHPC,
        LOADH, STOREH, LOADB, STOREB,
        LESSTHAN, LESSTHANOREQUAL, ULESSTHAN, ULESSTHANOREQUAL,
        LSHIFTRIGHT, ASHIFTLEFT, ASHIFTRIGHT,
        CALL, EQ, NEQ, NEG, SUB, XOR,
        EQBRANCH, NEQBRANCH, POPPCREL, PUSHSPADD, CALLREL, MULT
    } exe_op_t;

    typedef enum logic [1:0] {STAY, INC, DEC, TOS} sp_step_t;

    typedef enum logic [1:0] {STAY_SRC, INC_SRC, OFFSET_SRC, TOS_SRC} sp_src_t;

    // HOLD keeps the PC on BREAK, VECTOR is the emulate trap
    typedef enum logic [1:0] {ADVANCE, HOLD, VECTOR} pc_action_t;

endpackage

`default_nettype wire

// ==== dv/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
endfunction

// NOP, BREAK and unused native codes turn into ADDSP
function automatic opcode_t legal_op(input opcode_t op);
    if (op[7:4] == 4'h0 && (op[3:0] <= 4'd1 || op[3:0] == 4'd11 || op[3:0] >= 4'd14))
        return op | 8'h10;
    return op;
endfunction

// Big-endian byte of the program image
function automatic opcode_t fetch_byte(input logic [31:0] addr);
    logic [31:0] w;
    w = mem[addr[7:2]];
    case (addr[1:0])
        2'd0: return w[31:24];
        2'd1: return w[23:16];
        2'd2: return w[15:8];
        default: return w[7:0];
    endcase
endfunction

function automatic exe_op_t expect_op(input opcode_t op, input logic idim);
    logic [4:0] off;
    off = {~op[4], op[3:0]};
    if (op[7])
        return idim ? IMN : IM0;
    if (op[6:5] == 2'b10)
        return (off == 5'd1) ? STORESP1 : (off == 5'd2) ? STORESP2 : STORESP;
    if (op[6:5] == 2'b11)
        return LOADSP;
    if (op[6:5] == 2'b01) begin
        case (op[4:0])
            5'd2:  return LOADH;
            5'd3:  return STOREH;
            5'd4:  return LESSTHAN;
            5'd5:  return LESSTHANOREQUAL;
            5'd6:  return ULESSTHAN;
            5'd7:  return ULESSTHANOREQUAL;
            5'd9:  return MULT;
            5'd10: return LSHIFTRIGHT;
            5'd11: return ASHIFTLEFT;
            5'd12: return ASHIFTRIGHT;
            5'd13: return CALL;
            5'd14: return EQ;
            5'd15: return NEQ;
            5'd16: return NEG;
            5'd17: return SUB;
            5'd18: return XOR;
            5'd19: return LOADB;
            5'd20: return STOREB;
            5'd23: return EQBRANCH;
            5'd24: return NEQBRANCH;
            5'd25: return POPPCREL;
            5'd27: return PUSHPC;
            5'd29: return PUSHSPADD;
            5'd31: return CALLREL;
            default: return PUSHPC;  // Trap into software
        endcase
    end
    if (op[4])
        return ADDSP;
    case (op[3:0])
        4'd2:       return PUSHSP;
        4'd3, 4'd4: return POPPC;
        4'd5:       return ADD;
        4'd6:       return AND;
        4'd7:       return OR;
        4'd8:       return LOAD;
        4'd9:       return NOT;
        4'd10:      return FLIP;
        4'd12:      return STORE;
        4'd13:      return POPSP;
        default:    return NOP;
    endcase
endfunction

// Stack step in the upper half, address source in the lower
function automatic logic [3:0] sp_fields(input exe_op_t op);
    case (op)
        IM0, PUSHSP, PUSHPC: return {DEC, STAY_SRC};
        LOADSP:              return {DEC, OFFSET_SRC};
        ADDSP:               return {STAY, OFFSET_SRC};
        POPSP:               return {TOS, TOS_SRC};
        IMN, LOAD, NOT, FLIP, LOADH, LOADB, CALL, NEG, PUSHSPADD, CALLREL, NOP:
            return {STAY, STAY_SRC};
        default:             return {INC, INC_SRC};  // Pops one operand
    endcase
endfunction

task automatic check_equal(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
        $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
        $display("Simulation failed");
        $fatal(1);
    end
endtask

`endif

// ==== dv/tb_zpu_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_zpu_decode;
    import zpu_decode_pkg::*;

    localparam int NUM_ISSUE  = 2000;
    localparam int IDLE_LIMIT = 40;

    logic     clk = 1'b0;
    logic     rst;
    logic     stall;
    logic     flush;
    logic     enable;
    logic     interrupt;
    pc_t      new_pc;
    pc_t      int_addr;
    word_t    mem_data = '0;
    pc_t      fetch_addr;
    logic     fetch_en;
    logic     int_ack;
    exe_op_t  decoded_op;
    sp_step_t spstate;
    sp_src_t  spsource;
    offset_t  offset;
    instval_t inst_value;
    pc_t      pc_out;
    pc_t      next_pc_out;

    word_t       mem [64];
    logic [31:0] seed;
    pc_t         model_pc;
    logic        model_idim;
    logic        model_busy;  // Interrupt entry in progress
    logic        prev_hold;
    logic        prev_int;
    exe_op_t     last_op;
    logic [15:0] last_fields;
    pc_t         last_pc;
    pc_t         last_npc;
    int          issued;
    int          idle;

    `include "tb_model.svh"

    always #20 clk = ~clk;

    // Synchronous instruction memory
    always @(posedge clk) begin
        if (fetch_en)
            mem_data <= mem[fetch_addr[7:2]];
    end

    zpu_decode u_zpu_decode (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .flush       (flush),
        .enable      (enable),
        .interrupt   (interrupt),
        .new_pc      (new_pc),
        .int_addr    (int_addr),
        .mem_data    (mem_data),
        .fetch_addr  (fetch_addr),
        .fetch_en    (fetch_en),
        .int_ack     (int_ack),
        .decoded_op  (decoded_op),
        .spstate     (spstate),
        .spsource    (spsource),
        .offset      (offset),
        .inst_value  (inst_value),
        .pc_out      (pc_out),
        .next_pc_out (next_pc_out)
    );

    //////////////////////////////
    // Output checking against the model
    task automatic observe();
        opcode_t    op;
        exe_op_t    op_exp;
        logic [3:0] sp_exp;
        logic       entry;
        entry = 1'b0;
        if (prev_hold) begin
            check_equal("decoded_op", 32'(decoded_op), 32'(last_op));
            check_equal("spstate/spsource/offset/inst_value",
                        32'({spstate, spsource, offset, inst_value}), 32'(last_fields));
            check_equal("pc_out", pc_out, last_pc);
            check_equal("next_pc_out", next_pc_out, last_npc);
        end else if (decoded_op != NOP) begin
            op     = fetch_byte(model_pc);
            entry  = prev_int && !model_busy && !model_idim;
            op_exp = entry ? PUSHPC : expect_op(op, model_idim);
            sp_exp = entry ? {DEC, STAY_SRC} : sp_fields(op_exp);
            check_equal("decoded_op", 32'(decoded_op), 32'(op_exp));
            check_equal("spstate", 32'(spstate), 32'(sp_exp[3:2]));
            check_equal("spsource", 32'(spsource), 32'(sp_exp[1:0]));
            check_equal("offset", 32'(offset), 32'({~op[4], op[3:0]}));
            check_equal("inst_value", 32'(inst_value), 32'(op[6:0]));
            check_equal("pc_out", pc_out, model_pc);
            check_equal("next_pc_out", next_pc_out, entry ? model_pc : model_pc + 1);
            if (entry)
                model_pc = int_addr;
            else if (op[7:5] == 3'b001 && op_exp == PUSHPC && op[4:0] != 5'd27)
                model_pc = 32'(op[4:0]) << 5;  // Emulation vector
            else
                model_pc = model_pc + 1;
            if (!entry)
                model_idim = op[7];
            issued++;
            idle = 0;
        end
        if (entry)
            model_busy = 1'b1;
        else if (!prev_hold && !prev_int)
            model_busy = 1'b0;
        check_equal("int_ack", 32'(int_ack), 32'(model_busy));
        last_op     = decoded_op;
        last_fields = {spstate, spsource, offset, inst_value};
        last_pc     = pc_out;
        last_npc    = next_pc_out;
    endtask

    // Random stall, flush and interrupt for the coming cycle
    task automatic drive_inputs();
        seed  = xorshift(seed);
        stall = (seed[3:0] < 4'd3);
        flush = (seed[9:4] == 6'd0);
        if (!interrupt && !int_ack && seed[15:10] == 6'd0)
            interrupt = 1'b1;
        else if (interrupt && int_ack && seed[17:16] == 2'd0)
            interrupt = 1'b0;  // Drop only after the entry was taken
        new_pc    = 32'(seed[23:18]) << 2;
        prev_hold = stall && !flush;
        prev_int  = interrupt;
        if (flush) begin
            model_pc   = new_pc;
            model_idim = 1'b0;
            #5;
            check_equal("fetch_addr", fetch_addr, new_pc);
            check_equal("fetch_en", 32'(fetch_en), 32'd1);
        end
    endtask

    //////////////////////////////
    initial begin
        rst       = 1'b1;
        stall     = 1'b0;
        flush     = 1'b0;
        enable    = 1'b1;
        interrupt = 1'b0;
        new_pc    = '0;
        seed      = 32'h3e1a_c03a;
        for (int i = 0; i < 64; i++) begin
            seed          = xorshift(seed);
            mem[i[5:0]]   = {legal_op(seed[31:24]), legal_op(seed[23:16]),
                             legal_op(seed[15:8]), legal_op(seed[7:0])};
        end
        seed       = xorshift(seed);
        int_addr   = 32'(seed[7:2]) << 2;
        model_pc   = '0;
        model_idim = 1'b0;
        model_busy = 1'b0;
        prev_hold  = 1'b0;
        prev_int   = 1'b0;
        issued     = 0;
        idle       = 0;

        repeat (3) @(negedge clk);
        check_equal("decoded_op", 32'(decoded_op), 32'(NOP));
        check_equal("pc_out", pc_out, 32'd0);
        check_equal("int_ack", 32'(int_ack), 32'd0);
        rst = 1'b0;

        while (issued < NUM_ISSUE) begin
            @(negedge clk);
            idle++;
            observe();
            if (idle > IDLE_LIMIT) begin
                $display("Timeout: no instruction issued for %0d cycles", IDLE_LIMIT);
                $display("Simulation failed");
                $fatal(1);
            end
            drive_inputs();
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f src.f --top-module tb_zpu_decode -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== src.f ====
+incdir+dv
design/zpu_decode_pkg.sv
design/fetch_if.sv
design/fetch_ctrl.sv
design/opcode_decoder.sv
design/issue_regs.sv
design/zpu_decode.sv
dv/tb_zpu_decode.sv
